// File: source/l2_cache_pkg.sv
// Cache geometry and shared data types for the two-way L2 cache.
// Referenced by scoped names from every RTL block of the cache.

package l2_cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ADDR_W     = 32;                          // byte address width
	localparam int OFFSET_W   = 5;                           // byte offset inside a line
	localparam int INDEX_W    = 3;                           // set select bits
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W; // upper address bits
	localparam int NUM_SETS   = 2 ** INDEX_W;                // sets per way

	localparam int WORD_W     = 32;                          // cpu data width
	localparam int BE_W       = WORD_W / 8;                  // one enable per byte

	localparam int LINE_BYTES = 2 ** OFFSET_W;               // bytes per line, also mask width
	localparam int LINE_W     = 8 * LINE_BYTES;              // bits per line

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [ADDR_W-1:0]     addr_t;      // byte address
	typedef logic [WORD_W-1:0]     word_t;      // cpu word
	typedef logic [BE_W-1:0]       be_t;        // cpu byte enable
	typedef logic [INDEX_W-1:0]    index_t;     // set number
	typedef logic [TAG_W-1:0]      tag_t;       // stored tag
	typedef logic [LINE_W-1:0]     line_t;      // full cache line
	typedef logic [LINE_BYTES-1:0] line_mask_t; // per byte write mask of a line

	// address layout, msb first:
	//   [31:8] tag, [7:5] index, [4:0] offset
	// word inside a line comes from offset bits 4 to 2

endpackage : l2_cache_pkg

// File: source/cache_array.sv
// One way's storage: one payload entry per set, used for both tags and lines.
// Write at the clock edge, read combinationally at the current index.

`timescale 1ns/1ps

module cache_array #(
	parameter type payload_t = logic
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  l2_cache_pkg::index_t index_i,
	input  logic                 we_i,
	input  payload_t             wdata_i,
	output payload_t             rdata_o
);

	payload_t entry_q [l2_cache_pkg::NUM_SETS];   // one entry per set

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < l2_cache_pkg::NUM_SETS; s++) begin
				entry_q[s] <= '0;
			end
		end else if (we_i) begin
			entry_q[index_i] <= wdata_i;           // visible next cycle
		end
	end

	assign rdata_o = entry_q[index_i];             // no read latency

endmodule : cache_array

// File: source/bus_adapter.sv
// Converts between CPU words and cache lines.
// Builds write line and byte mask from the word, picks the addressed word from the hit line.

`timescale 1ns/1ps

module bus_adapter (
	input  l2_cache_pkg::addr_t      mem_address_i,
	input  l2_cache_pkg::word_t      mem_wdata_i,
	input  l2_cache_pkg::be_t        mem_byte_enable_i,
	input  l2_cache_pkg::line_t      hit_line_i,
	output l2_cache_pkg::line_t      cpu_wline_o,
	output l2_cache_pkg::line_mask_t cpu_line_mask_o,
	output l2_cache_pkg::word_t      mem_rdata_o
);

	localparam int WORDS = l2_cache_pkg::LINE_W / l2_cache_pkg::WORD_W;  // slots per line

	logic [l2_cache_pkg::OFFSET_W-3:0] word_sel;   // offset bits 4 to 2

	assign word_sel = mem_address_i[l2_cache_pkg::OFFSET_W-1:2];

	// same word in every slot, the mask picks the live one
	assign cpu_wline_o = {WORDS{mem_wdata_i}};

	// byte enable moved to the slot's byte lanes
	assign cpu_line_mask_o = l2_cache_pkg::line_mask_t'(mem_byte_enable_i) << {word_sel, 2'b00};

	assign mem_rdata_o = hit_line_i[word_sel*l2_cache_pkg::WORD_W +: l2_cache_pkg::WORD_W];

endmodule : bus_adapter

// File: source/cache_control.sv
// Cache controller FSM: serves hits in CHECK, then sequences writeback and fill on a miss.
// All outputs are decoded from the current state and the live inputs.

`timescale 1ns/1ps

module cache_control (
	input  logic clk_i,
	input  logic rst_n_i,

	// cpu strobes
	input  logic mem_read_i,
	input  logic mem_write_i,

	// datapath status
	input  logic hit_i,
	input  logic victim_dirty_i,

	// memory handshake
	input  logic pmem_resp_i,

	output logic mem_resp_o,
	output logic cpu_write_en_o,
	output logic lru_update_o,
	output logic fill_en_o,
	output logic writeback_sel_o,
	output logic pmem_read_o,
	output logic pmem_write_o
);

	typedef enum logic [1:0] {
		CHECK,     // idle or serving a hit
		WRITEBACK, // dirty victim goes out to memory
		FILL       // missing line comes in from memory
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   req;   // cpu has a request pending

	assign req = mem_read_i | mem_write_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= CHECK;
		end else begin
			state_q <= state_d;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state and outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_d         = state_q;
		mem_resp_o      = 1'b0;
		cpu_write_en_o  = 1'b0;
		lru_update_o    = 1'b0;
		fill_en_o       = 1'b0;
		writeback_sel_o = 1'b0;
		pmem_read_o     = 1'b0;
		pmem_write_o    = 1'b0;

		unique case (state_q)
			CHECK: begin
				if (req && hit_i) begin
					mem_resp_o     = 1'b1;        // zero wait hit
					lru_update_o   = 1'b1;
					cpu_write_en_o = mem_write_i; // write lands at this edge
				end else if (req) begin
					// miss, victim decides whether a writeback comes first
					state_d = victim_dirty_i ? WRITEBACK : FILL;
				end
			end

			WRITEBACK: begin
				pmem_write_o    = 1'b1;       // held until memory answers
				writeback_sel_o = 1'b1;       // address from victim tag
				if (pmem_resp_i) begin
					state_d = FILL;
				end
			end

			FILL: begin
				pmem_read_o = 1'b1;           // cpu address, line aligned
				if (pmem_resp_i) begin
					fill_en_o = 1'b1;         // rdata valid this cycle only
					state_d   = CHECK;        // next cycle is a hit
				end
			end

			default: begin
				state_d = CHECK;
			end
		endcase
	end

endmodule : cache_control

// File: source/cache_datapath.sv
// Storage and compare logic of the cache: tag and data arrays of both ways,
// valid, dirty and LRU state, hit detection, victim choice, line merge and memory address.

`timescale 1ns/1ps

module cache_datapath (
	input  logic                     clk_i,
	input  logic                     rst_n_i,

	input  l2_cache_pkg::addr_t      mem_address_i,
	input  l2_cache_pkg::line_t      cpu_wline_i,
	input  l2_cache_pkg::line_mask_t cpu_line_mask_i,

	// controller commands
	input  logic                     cpu_write_en_i,
	input  logic                     lru_update_i,
	input  logic                     fill_en_i,
	input  logic                     writeback_sel_i,

	input  l2_cache_pkg::line_t      pmem_rdata_i,

	output logic                     hit_o,
	output logic                     victim_dirty_o,
	output l2_cache_pkg::line_t      hit_line_o,
	output l2_cache_pkg::line_t      pmem_wdata_o,
	output l2_cache_pkg::addr_t      pmem_address_o
);

	localparam int NUM_WAYS = 2;

	l2_cache_pkg::tag_t   addr_tag;                 // tag part of cpu address
	l2_cache_pkg::index_t idx;                      // set part of cpu address

	l2_cache_pkg::tag_t   tag_rd  [NUM_WAYS];       // stored tag per way
	l2_cache_pkg::line_t  data_rd [NUM_WAYS];       // stored line per way
	logic [NUM_WAYS-1:0]  tag_we;
	logic [NUM_WAYS-1:0]  data_we;
	l2_cache_pkg::line_t  data_wr;                  // fill line or merged line

	logic [NUM_WAYS-1:0][l2_cache_pkg::NUM_SETS-1:0] valid_q;
	logic [NUM_WAYS-1:0][l2_cache_pkg::NUM_SETS-1:0] dirty_q;
	logic [l2_cache_pkg::NUM_SETS-1:0]               lru_q;    // way to evict next

	logic [NUM_WAYS-1:0]  way_hit;
	logic                 hit_way;                  // way that hits, 0 if none
	logic                 victim;                   // lru way of this set
	l2_cache_pkg::line_t  merged_line;              // hit line with cpu bytes in

	assign addr_tag = mem_address_i[l2_cache_pkg::ADDR_W-1 -: l2_cache_pkg::TAG_W];
	assign idx      = mem_address_i[l2_cache_pkg::OFFSET_W +: l2_cache_pkg::INDEX_W];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// way storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
		assign way_hit[w] = valid_q[w][idx] && (tag_rd[w] == addr_tag);
		assign tag_we[w]  = fill_en_i && (victim == 1'(w));           // tag only on fill
		assign data_we[w] = (fill_en_i && (victim == 1'(w))) ||
		                    (cpu_write_en_i && way_hit[w]);

		cache_array #(
			.payload_t(l2_cache_pkg::tag_t)
		) i_tag_array (
			.clk_i  (clk_i),
			.rst_n_i(rst_n_i),
			.index_i(idx),
			.we_i   (tag_we[w]),
			.wdata_i(addr_tag),
			.rdata_o(tag_rd[w])
		);

		cache_array #(
			.payload_t(l2_cache_pkg::line_t)
		) i_data_array (
			.clk_i  (clk_i),
			.rst_n_i(rst_n_i),
			.index_i(idx),
			.we_i   (data_we[w]),
			.wdata_i(data_wr),
			.rdata_o(data_rd[w])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hit, victim and line merge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign hit_o          = |way_hit;
	assign hit_way        = way_hit[1];                          // ways never both hit
	assign hit_line_o     = data_rd[hit_way];
	assign victim         = lru_q[idx];
	assign victim_dirty_o = valid_q[victim][idx] && dirty_q[victim][idx];

	always_comb begin
		for (int b = 0; b < l2_cache_pkg::LINE_BYTES; b++) begin
			merged_line[8*b +: 8] = cpu_line_mask_i[b] ? cpu_wline_i[8*b +: 8]
			                                           : hit_line_o[8*b +: 8];
		end
	end

	assign data_wr = fill_en_i ? pmem_rdata_i : merged_line;

	// memory side, always line aligned
	assign pmem_wdata_o   = data_rd[victim];
	assign pmem_address_o = writeback_sel_i
		? {tag_rd[victim], idx, {l2_cache_pkg::OFFSET_W{1'b0}}}  // victim line
		: {addr_tag, idx, {l2_cache_pkg::OFFSET_W{1'b0}}};       // missing line

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// valid, dirty and lru bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q   <= '0;                                   // way 0 goes first
		end else begin
			if (fill_en_i) begin
				valid_q[victim][idx] <= 1'b1;                // fresh line is clean
				dirty_q[victim][idx] <= 1'b0;
			end
			if (cpu_write_en_i) begin
				dirty_q[hit_way][idx] <= 1'b1;
			end
			if (lru_update_i) begin
				lru_q[idx] <= ~hit_way;                      // other way is now oldest
			end
		end
	end

endmodule : cache_datapath

// File: source/l2_cache.sv
// Top level of the two-way write-back L2 cache.
// Wires the controller, datapath and bus adapter between CPU and memory ports.

`timescale 1ns/1ps

module l2_cache (
	input  logic                  clk_i,
	input  logic                  rst_n_i,

	// cpu side
	input  l2_cache_pkg::addr_t   mem_address_i,
	input  logic                  mem_read_i,
	input  logic                  mem_write_i,
	input  l2_cache_pkg::word_t   mem_wdata_i,
	input  l2_cache_pkg::be_t     mem_byte_enable_i,
	output l2_cache_pkg::word_t   mem_rdata_o,
	output logic                  mem_resp_o,

	// memory side
	input  l2_cache_pkg::line_t   pmem_rdata_i,
	input  logic                  pmem_resp_i,
	output l2_cache_pkg::line_t   pmem_wdata_o,
	output l2_cache_pkg::addr_t   pmem_address_o,
	output logic                  pmem_read_o,
	output logic                  pmem_write_o
);

	// datapath status to the controller
	logic                     hit;           // address hits one way
	logic                     victim_dirty;  // lru way holds modified data

	// controller commands to the datapath
	logic                     cpu_write_en;  // merge cpu bytes into hit way
	logic                     lru_update;    // hit seen, move lru away
	logic                     fill_en;       // load memory line into victim
	logic                     writeback_sel; // memory address from victim tag

	// word and line conversion
	l2_cache_pkg::line_t      cpu_wline;     // word copied to all slots
	l2_cache_pkg::line_mask_t cpu_line_mask; // bytes the cpu writes
	l2_cache_pkg::line_t      hit_line;      // line of the hit way

	cache_control i_control (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.mem_read_i     (mem_read_i),
		.mem_write_i    (mem_write_i),
		.hit_i          (hit),
		.victim_dirty_i (victim_dirty),
		.pmem_resp_i    (pmem_resp_i),
		.mem_resp_o     (mem_resp_o),
		.cpu_write_en_o (cpu_write_en),
		.lru_update_o   (lru_update),
		.fill_en_o      (fill_en),
		.writeback_sel_o(writeback_sel),
		.pmem_read_o    (pmem_read_o),
		.pmem_write_o   (pmem_write_o)
	);

	cache_datapath i_datapath (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.mem_address_i  (mem_address_i),
		.cpu_wline_i    (cpu_wline),
		.cpu_line_mask_i(cpu_line_mask),
		.cpu_write_en_i (cpu_write_en),
		.lru_update_i   (lru_update),
		.fill_en_i      (fill_en),
		.writeback_sel_i(writeback_sel),
		.pmem_rdata_i   (pmem_rdata_i),
		.hit_o          (hit),
		.victim_dirty_o (victim_dirty),
		.hit_line_o     (hit_line),
		.pmem_wdata_o   (pmem_wdata_o),
		.pmem_address_o (pmem_address_o)
	);

	bus_adapter i_bus_adapter (
		.mem_address_i    (mem_address_i),
		.mem_wdata_i      (mem_wdata_i),
		.mem_byte_enable_i(mem_byte_enable_i),
		.hit_line_i       (hit_line),
		.cpu_wline_o      (cpu_wline),
		.cpu_line_mask_o  (cpu_line_mask),
		.mem_rdata_o      (mem_rdata_o)
	);

endmodule : l2_cache

// File: testbench/memory_model.sv
// Line-wide backing memory for the cache testbench, with random response latency.
// Untouched words read as their byte address XOR INIT_XOR; handshakes are counted.

`timescale 1ns/1ps

module memory_model #(
	parameter logic [31:0] INIT_XOR = 32'h5A5A_0000,
	parameter logic [31:0] SEED     = 32'd64
) (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                read_i,
	input  logic                write_i,
	input  l2_cache_pkg::addr_t address_i,
	input  l2_cache_pkg::line_t wdata_i,
	output l2_cache_pkg::line_t rdata_o = '0,
	output logic                resp_o = 1'b0
);

	l2_cache_pkg::line_t mem [l2_cache_pkg::addr_t];   // only lines written back
	l2_cache_pkg::addr_t base;                          // line aligned address
	logic [31:0]         lcg_q = SEED;
	int                  wait_cnt = 0;                  // falling edges left to resp
	logic                busy = 1'b0;                   // latency drawn for this strobe

	int                  read_count = 0;                // read handshakes, seen by tb
	int                  write_count = 0;               // write handshakes, seen by tb
	l2_cache_pkg::addr_t last_write_addr = '0;

	assign base = {address_i[l2_cache_pkg::ADDR_W-1:l2_cache_pkg::OFFSET_W],
	               {l2_cache_pkg::OFFSET_W{1'b0}}};

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// stored line, or the address rule for a line never written
	function automatic l2_cache_pkg::line_t line_at(input l2_cache_pkg::addr_t a);
		l2_cache_pkg::line_t line;
		if (mem.exists(a)) begin
			return mem[a];
		end
		for (int w = 0; w < 8; w++) begin
			line[32*w +: 32] = (a + 32'(4 * w)) ^ INIT_XOR;   // byte address of word w
		end
		return line;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake, driven on the falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			resp_o   <= 1'b0;
			rdata_o  <= '0;
			busy     = 1'b0;
			wait_cnt = 0;
		end else if (resp_o) begin
			resp_o <= 1'b0;                                 // one cycle pulse
		end else if (read_i || write_i) begin
			if (!busy) begin
				lcg_q    = lcg_step(lcg_q);
				wait_cnt = 1 + int'(lcg_q[18:16]);          // 1 to 8 cycles
				busy     = 1'b1;
			end
			wait_cnt--;
			if (wait_cnt == 0) begin
				busy = 1'b0;
				if (write_i) begin
					mem[base]       = wdata_i;
					write_count++;
					last_write_addr = base;
				end else begin
					rdata_o <= line_at(base);               // valid with resp only
					read_count++;
				end
				resp_o <= 1'b1;
			end
		end
	end

endmodule : memory_model

// File: testbench/l2_cache_tb.sv
// Self-checking testbench for the two-way L2 cache.
// Directed hit, miss, eviction and LRU cases, then random traffic against a shadow model.

`timescale 1ns/1ps

module l2_cache_tb;

	localparam int          CLK_PERIOD   = 40;
	localparam int          RAND_OPS     = 400;
	localparam int          DIRECTED_OPS = 40;             // rounded up
	localparam logic [31:0] INIT_XOR     = 32'h5A5A_0000;

	logic                     clk = 1'b0;
	logic                     rst_n;
	l2_cache_pkg::addr_t      mem_address;
	logic                     mem_read;
	logic                     mem_write;
	l2_cache_pkg::word_t      mem_wdata;
	l2_cache_pkg::be_t        mem_byte_enable;
	l2_cache_pkg::word_t      mem_rdata;
	logic                     mem_resp;
	l2_cache_pkg::line_t      pmem_rdata;
	logic                     pmem_resp;
	l2_cache_pkg::line_t      pmem_wdata;
	l2_cache_pkg::addr_t      pmem_address;
	logic                     pmem_read;
	logic                     pmem_write;

	l2_cache_pkg::word_t      shadow [l2_cache_pkg::addr_t];   // every word written so far
	l2_cache_pkg::word_t      exp_rdata;                       // expected word of current read
	logic [31:0]              lcg_state = 32'd64;

	l2_cache i_dut (
		.clk_i(clk), .rst_n_i(rst_n),
		.mem_address_i(mem_address), .mem_read_i(mem_read), .mem_write_i(mem_write),
		.mem_wdata_i(mem_wdata), .mem_byte_enable_i(mem_byte_enable),
		.mem_rdata_o(mem_rdata), .mem_resp_o(mem_resp),
		.pmem_rdata_i(pmem_rdata), .pmem_resp_i(pmem_resp), .pmem_wdata_o(pmem_wdata),
		.pmem_address_o(pmem_address), .pmem_read_o(pmem_read), .pmem_write_o(pmem_write)
	);

	memory_model #(.INIT_XOR(INIT_XOR), .SEED(32'd64)) i_mem (
		.clk_i(clk), .rst_n_i(rst_n), .read_i(pmem_read), .write_i(pmem_write),
		.address_i(pmem_address), .wdata_i(pmem_wdata), .rdata_o(pmem_rdata),
		.resp_o(pmem_resp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic l2_cache_pkg::addr_t make_addr(input l2_cache_pkg::tag_t tag,
	                                                  input l2_cache_pkg::index_t idx,
	                                                  input logic [2:0] word);
		return {tag, idx, word, 2'b00};
	endfunction

	// reference: last written value, else the memory fill rule
	function automatic l2_cache_pkg::word_t expected_word(input l2_cache_pkg::addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ INIT_XOR;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// one cpu request, called at a falling edge, returns cycles until resp
	task automatic do_access(input l2_cache_pkg::addr_t addr, input logic is_write,
	                         input l2_cache_pkg::word_t wdata, input l2_cache_pkg::be_t be,
	                         output int cycles);
		l2_cache_pkg::word_t word;
		word            = expected_word(addr);
		exp_rdata       = word;
		mem_address     = addr;
		mem_read        = ~is_write;
		mem_write       = is_write;
		mem_wdata       = wdata;
		mem_byte_enable = be;
		cycles          = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!mem_resp);
		if (is_write) begin
			for (int b = 0; b < 4; b++) begin
				if (be[b]) word[8*b +: 8] = wdata[8*b +: 8];   // enabled bytes only
			end
			shadow[addr] = word;
		end
		@(negedge clk);
		mem_read  = 1'b0;
		mem_write = 1'b0;
	endtask

	// read data compare, sampled where outputs are settled
	always @(posedge clk) begin
		if (mem_resp && mem_read) begin
			check_value("mem_rdata_o", mem_rdata, exp_rdata);
		end
		if (pmem_read || pmem_write) begin
			check_value("pmem_address_o[4:0]", 32'(pmem_address[4:0]), 32'd0);   // line aligned
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int                  cyc;
		int                  rd0;
		int                  wr0;
		logic [31:0]         r;
		l2_cache_pkg::addr_t a;

		rst_n = 1'b0;
		mem_address = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		repeat (4) begin                                    // idle after reset
			@(posedge clk);
			check_value("mem_resp_o", 32'(mem_resp), 32'd0);
			check_value("pmem_read_o", 32'(pmem_read), 32'd0);
			check_value("pmem_write_o", 32'(pmem_write), 32'd0);
		end
		@(negedge clk);

		// read miss, then zero wait hit on the same line
		rd0 = i_mem.read_count;
		do_access(make_addr(24'h000010, 3'd3, 3'd2), 1'b0, '0, '0, cyc);
		check_value("pmem_read_count", i_mem.read_count, rd0 + 1);
		do_access(make_addr(24'h000010, 3'd3, 3'd5), 1'b0, '0, '0, cyc);
		check_value("hit_cycles", cyc, 1);
		check_value("pmem_read_count", i_mem.read_count, rd0 + 1);

		// byte enabled writes into the resident line
		rd0 = i_mem.read_count;
		wr0 = i_mem.write_count;
		for (int i = 0; i < 5; i++) begin
			a = make_addr(24'h000010, 3'd3, 3'(i));
			do_access(a, 1'b1, 32'hA5C3_0F00 + 32'(i), l2_cache_pkg::be_t'(i * 3 + 1), cyc);
		end
		do_access(make_addr(24'h000010, 3'd3, 3'd2), 1'b1, 32'h1234_5678, 4'b1001, cyc);
		for (int i = 0; i < 5; i++) begin
			do_access(make_addr(24'h000010, 3'd3, 3'(i)), 1'b0, '0, '0, cyc);
		end
		check_value("pmem_read_count", i_mem.read_count, rd0);
		check_value("pmem_write_count", i_mem.write_count, wr0);

		// dirty eviction, third tag in set 5 pushes A out
		wr0 = i_mem.write_count;
		do_access(make_addr(24'h0000A1, 3'd5, 3'd1), 1'b1, 32'h1111_2222, 4'hF, cyc);
		do_access(make_addr(24'h0000B2, 3'd5, 3'd1), 1'b1, 32'h3333_4444, 4'hF, cyc);
		check_value("pmem_write_count", i_mem.write_count, wr0);
		do_access(make_addr(24'h0000C3, 3'd5, 3'd1), 1'b1, 32'h5555_6666, 4'hF, cyc);
		check_value("pmem_write_count", i_mem.write_count, wr0 + 1);
		check_value("pmem_address_o", i_mem.last_write_addr, make_addr(24'h0000A1, 3'd5, 3'd0));
		rd0 = i_mem.read_count;
		do_access(make_addr(24'h0000A1, 3'd5, 3'd1), 1'b0, '0, '0, cyc);   // refilled from memory
		check_value("pmem_read_count", i_mem.read_count, rd0 + 1);

		// lru order: D, E, D again, then F evicts E
		do_access(make_addr(24'h0000D1, 3'd6, 3'd0), 1'b0, '0, '0, cyc);
		do_access(make_addr(24'h0000E2, 3'd6, 3'd0), 1'b0, '0, '0, cyc);
		do_access(make_addr(24'h0000D1, 3'd6, 3'd4), 1'b0, '0, '0, cyc);
		do_access(make_addr(24'h0000F3, 3'd6, 3'd0), 1'b0, '0, '0, cyc);
		rd0 = i_mem.read_count;
		do_access(make_addr(24'h0000D1, 3'd6, 3'd7), 1'b0, '0, '0, cyc);
		check_value("pmem_read_count", i_mem.read_count, rd0);
		do_access(make_addr(24'h0000E2, 3'd6, 3'd7), 1'b0, '0, '0, cyc);
		check_value("pmem_read_count", i_mem.read_count, rd0 + 1);

		// random traffic over 4 tags and all sets
		for (int n = 0; n < RAND_OPS; n++) begin
			lcg_state = lcg_step(lcg_state);
			r         = lcg_state;
			a         = make_addr({22'h003000, r[17:16]}, r[20:18], r[23:21]);
			lcg_state = lcg_step(lcg_state);
			do_access(a, r[24], lcg_state, lcg_state[19:16], cyc);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

	// watchdog, about 40 cycles per operation
	initial begin
		#((RAND_OPS + DIRECTED_OPS) * 40 * CLK_PERIOD);
		$display("timeout: the cache stopped answering requests before the tests ended");
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule : l2_cache_tb

// File: l2_cache.f
source/l2_cache_pkg.sv
source/cache_array.sv
source/bus_adapter.sv
source/cache_control.sv
source/cache_datapath.sv
source/l2_cache.sv
testbench/memory_model.sv
testbench/l2_cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the cache and its testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module l2_cache_tb -f l2_cache.f -o l2_cache_sim \
	&& ./obj_dir/l2_cache_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
